/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = viaTb
FILELIST  = via6522.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/viaIrqPkg.sv */
package viaIrqPkg;

	// Width of IFR and IER without bit 7.
	localparam int VIA_IRQ_BITS = 7;

	// Timer 1 counter and latch.
	localparam int T1_WIDTH = 16;

	// ##########################################################################
	// IFR bit positions
	// ##########################################################################

	localparam int IFR_CA2 = 0;
	localparam int IFR_CA1 = 1;
	localparam int IFR_SR  = 2;
	localparam int IFR_CB2 = 3;
	localparam int IFR_CB1 = 4;
	localparam int IFR_T2  = 5;
	localparam int IFR_T1  = 6;

	// Edge events from the control lines.
	typedef struct packed {
		logic ca1;
		logic ca2;
		logic cb1;
		logic cb2;
	} viaEdgeFlags;

	// Flag clears caused by register accesses.
	typedef struct packed {
		logic portA;	// ORA or ORANH, read or write.
		logic portB;	// ORB, read or write.
		logic timer;	// T1L read or T1H write.
	} viaIrqClear;

endpackage

/* common/viaRegPkg.sv */
package viaRegPkg;

	// Register select codes on RS3..RS0.
	typedef enum logic [3:0] {
		REG_ORB   = 4'h0,
		REG_ORA   = 4'h1,
		REG_DDRB  = 4'h2,
		REG_DDRA  = 4'h3,
		REG_T1L   = 4'h4,	// Counter low on read, latch low on write.
		REG_T1H   = 4'h5,	// Counter high, a write starts the timer.
		REG_T1LL  = 4'h6,
		REG_T1LH  = 4'h7,
		REG_SR    = 4'hA,
		REG_ACR   = 4'hB,
		REG_PCR   = 4'hC,
		REG_IFR   = 4'hD,
		REG_IER   = 4'hE,
		REG_ORANH = 4'hF	// Port A without handshake.
	} viaRegSel;

	// One qualified CPU cycle. All three strobes already carry clkEn.
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic       idle;	// Enabled cycle, chip not selected.
		viaRegSel   sel;
		logic [7:0] data;
	} viaBusCycle;

	// Write data for IER and IFR.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       setClr;	// IER only. 1 sets, 0 clears.
			logic [6:0] mask;
		} sc;
	} viaFlagWrite;

	// Readback from the port block.
	typedef struct packed {
		logic [7:0] portA;	// Output/pin merge.
		logic [7:0] portB;
		logic [7:0] ddrA;
		logic [7:0] ddrB;
		logic [7:0] sr;
		logic [7:0] acr;
		logic [7:0] pcr;
	} viaPortRead;

endpackage

/* design/via6522.sv */
module via6522 (
	input  logic                clk,
	input  logic                nRESET,
	input  logic                clkEn,
	input  logic                cs1,
	input  logic                nCs2,
	input  logic                phi2,
	input  logic                rnW,
	input  viaRegPkg::viaRegSel rs,
	input  logic [7:0]          dataIn,
	output logic [7:0]          dataOut,
	output logic                dataOe,
	input  logic [7:0]          portAIn,
	input  logic [7:0]          portBIn,
	output logic [7:0]          portAOut,
	output logic [7:0]          portAOe,
	output logic [7:0]          portBOut,
	output logic [7:0]          portBOe,
	input  logic                ca1,
	input  logic                ca2,
	input  logic                cb1,
	input  logic                cb2,
	output logic                nIrq
);
	import viaRegPkg::*;
	import viaIrqPkg::*;

	viaBusCycle            cycle;
	viaIrqClear            irqClear;
	viaPortRead            portRead;
	viaEdgeFlags           edges;
	logic                  timeout;
	logic [T1_WIDTH-1:0]   t1Counter;
	logic [T1_WIDTH-1:0]   t1Latch;
	logic [7:0]            ifrByte;
	logic [7:0]            ierByte;

	viaBusDecode uBusDecode (
		.clkEn, .cs1, .nCs2, .phi2, .rnW, .rs, .dataIn,
		.cycle, .irqClear, .portRead, .t1Counter, .t1Latch,
		.ifrByte, .ierByte, .dataOut, .dataOe
	);

	// Ports and timer run side by side.
	viaPortCtrl uPortCtrl (
		.clk, .nRESET, .cycle,
		.ca1, .ca2, .cb1, .cb2,
		.portAIn, .portBIn, .portAOut, .portAOe, .portBOut, .portBOe,
		.edges, .portRead
	);

	viaTimer1 uTimer1 (
		.clk, .nRESET, .cycle, .timeout,
		.counter (t1Counter),
		.latch   (t1Latch)
	);

	viaIrqCtrl uIrqCtrl (
		.clk, .nRESET, .cycle, .edges, .timeout, .irqClear,
		.ifrByte, .ierByte, .nIrq
	);

endmodule

/* design/viaBusDecode.sv */
module viaBusDecode (
	input  logic                           clkEn,
	input  logic                           cs1,
	input  logic                           nCs2,
	input  logic                           phi2,
	input  logic                           rnW,
	input  viaRegPkg::viaRegSel            rs,
	input  logic [7:0]                     dataIn,
	output viaRegPkg::viaBusCycle          cycle,
	output viaIrqPkg::viaIrqClear          irqClear,
	input  viaRegPkg::viaPortRead          portRead,
	input  logic [viaIrqPkg::T1_WIDTH-1:0] t1Counter,
	input  logic [viaIrqPkg::T1_WIDTH-1:0] t1Latch,
	input  logic [7:0]                     ifrByte,
	input  logic [7:0]                     ierByte,
	output logic [7:0]                     dataOut,
	output logic                           dataOe
);
	import viaRegPkg::*;
	import viaIrqPkg::*;

	logic chipSel;
	logic access;	// Enabled cycle with chip selected.
	logic [7:0] readByte;

	assign chipSel = cs1 & ~nCs2;
	assign access  = chipSel & clkEn;

	// ##########################################################################
	// Qualified bus cycle
	// ##########################################################################

	always_comb begin
		cycle.wr   = access & ~rnW;
		cycle.rd   = access & rnW;
		cycle.idle = clkEn & ~chipSel;	// Lets pending edges through.
		cycle.sel  = rs;
		cycle.data = dataIn;
	end

	// Side-effect clears, any direction on the ports.
	always_comb begin
		irqClear.portA = access & ((rs == REG_ORA) | (rs == REG_ORANH));
		irqClear.portB = access & (rs == REG_ORB);
		irqClear.timer = (cycle.rd & (rs == REG_T1L)) | (cycle.wr & (rs == REG_T1H));
	end

	// ##########################################################################
	// Readback
	// ##########################################################################

	always_comb begin
		case (rs)
			REG_ORB:            readByte = portRead.portB;
			REG_ORA, REG_ORANH: readByte = portRead.portA;
			REG_DDRB:           readByte = portRead.ddrB;
			REG_DDRA:           readByte = portRead.ddrA;
			REG_T1L:            readByte = t1Counter[7:0];
			REG_T1H:            readByte = t1Counter[T1_WIDTH-1:8];
			REG_T1LL:           readByte = t1Latch[7:0];
			REG_T1LH:           readByte = t1Latch[T1_WIDTH-1:8];
			REG_SR:             readByte = portRead.sr;
			REG_ACR:            readByte = portRead.acr;
			REG_PCR:            readByte = portRead.pcr;
			REG_IFR:            readByte = ifrByte;
			REG_IER:            readByte = ierByte;
			default:            readByte = 8'h00;	// T2 codes, not kept.
		endcase
	end

	assign dataOut = readByte;
	assign dataOe  = phi2 & chipSel & rnW;	// Drive only in the read half.

endmodule

/* design/viaIrqCtrl.sv */
module viaIrqCtrl (
	input  logic                   clk,
	input  logic                   nRESET,
	input  viaRegPkg::viaBusCycle  cycle,
	input  viaIrqPkg::viaEdgeFlags edges,
	input  logic                   timeout,
	input  viaIrqPkg::viaIrqClear  irqClear,
	output logic [7:0]             ifrByte,
	output logic [7:0]             ierByte,
	output logic                   nIrq
);
	import viaRegPkg::*;
	import viaIrqPkg::*;

	logic en;
	logic [VIA_IRQ_BITS-1:0] ifr, ier;
	logic [VIA_IRQ_BITS-1:0] setVec, clrVec;
	logic [VIA_IRQ_BITS-1:0] active;
	viaFlagWrite flagWr;

	assign en          = cycle.wr | cycle.rd | cycle.idle;
	assign flagWr.raw  = cycle.data;
	assign active      = ifr & ier;

	always_comb begin
		setVec          = '0;
		setVec[IFR_CA2] = edges.ca2;
		setVec[IFR_CA1] = edges.ca1;
		setVec[IFR_SR]  = 1'b0;	// No SR or T2 source in this model.
		setVec[IFR_CB2] = edges.cb2;
		setVec[IFR_CB1] = edges.cb1;
		setVec[IFR_T2]  = 1'b0;
		setVec[IFR_T1]  = timeout;

		clrVec          = '0;
		clrVec[IFR_CA2] = irqClear.portA;
		clrVec[IFR_CA1] = irqClear.portA;
		clrVec[IFR_CB2] = irqClear.portB;
		clrVec[IFR_CB1] = irqClear.portB;
		clrVec[IFR_T1]  = irqClear.timer;
		if (cycle.wr && (cycle.sel == REG_IFR)) begin
			clrVec = clrVec | flagWr.sc.mask;	// Ones clear.
		end
	end

	// Clear beats set.
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ifr <= '0;
			ier <= '0;
		end else if (en) begin
			ifr <= (ifr | setVec) & ~clrVec;
			if (cycle.wr && (cycle.sel == REG_IER)) begin
				ier <= flagWr.sc.setClr ? (ier | flagWr.sc.mask) : (ier & ~flagWr.sc.mask);
			end
		end
	end

	// Runs every clk.
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			nIrq <= 1'b1;
		end else begin
			nIrq <= ~|active;
		end
	end

	assign ifrByte = {|active, ifr};
	assign ierByte = {1'b1, ier};

endmodule

/* ports/viaPortCtrl.sv */
module viaPortCtrl (
	input  logic                   clk,
	input  logic                   nRESET,
	input  viaRegPkg::viaBusCycle  cycle,
	input  logic                   ca1,
	input  logic                   ca2,
	input  logic                   cb1,
	input  logic                   cb2,
	input  logic [7:0]             portAIn,
	input  logic [7:0]             portBIn,
	output logic [7:0]             portAOut,
	output logic [7:0]             portAOe,
	output logic [7:0]             portBOut,
	output logic [7:0]             portBOe,
	output viaIrqPkg::viaEdgeFlags edges,
	output viaRegPkg::viaPortRead  portRead
);
	import viaRegPkg::*;
	import viaIrqPkg::*;

	logic [7:0] ora, orb, ddra, ddrb;
	logic [7:0] acr, pcr, sr;
	logic en;
	viaEdgeFlags lineQ, lineQQ;	// Input stage, then previous value.
	viaEdgeFlags pol;	// 1 selects the rising edge.
	viaEdgeFlags detect;
	viaEdgeFlags pending;
	logic shiftPending;
	logic shiftBit;	// CB2 level at the CB1 edge.

	// Output register where driven, pin otherwise.
	function automatic logic [7:0] pinMerge(input logic [7:0] outReg, input logic [7:0] ddr,
			input logic [7:0] pins);
		return (outReg & ddr) | (pins & ~ddr);
	endfunction

	assign en = cycle.wr | cycle.rd | cycle.idle;

	// ##########################################################################
	// Port, DDR and control registers
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ora  <= '0;
			orb  <= '0;
			ddra <= '0;
			ddrb <= '0;
			acr  <= '0;
			pcr  <= '0;
		end else if (cycle.wr) begin
			case (cycle.sel)
				REG_ORB:            orb  <= cycle.data;
				REG_ORA, REG_ORANH: ora  <= cycle.data;
				REG_DDRB:           ddrb <= cycle.data;
				REG_DDRA:           ddra <= cycle.data;
				REG_ACR:            acr  <= cycle.data;	// Storage only.
				REG_PCR:            pcr  <= cycle.data;
				default: ;
			endcase
		end
	end

	assign portAOut = ora;
	assign portAOe  = ddra;
	assign portBOut = orb;
	assign portBOe  = ddrb;

	// ##########################################################################
	// Control line edges, sampled on every clk
	// ##########################################################################

	always_ff @(posedge clk) begin
		lineQ  <= '{ca1: ca1, ca2: ca2, cb1: cb1, cb2: cb2};
		lineQQ <= lineQ;
	end

	assign pol    = '{ca1: pcr[0], ca2: pcr[2], cb1: pcr[4], cb2: pcr[6]};
	assign detect = (lineQ & ~lineQQ & pol) | (~lineQ & lineQQ & ~pol);

	// Edges wait here while the CPU keeps the chip selected.
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			pending <= '0;
		end else if (cycle.idle) begin
			pending <= detect;	// Handed over, keep only fresh ones.
		end else begin
			pending <= pending | detect;
		end
	end

	assign edges = cycle.idle ? pending : '0;

	// ##########################################################################
	// Shift-in register
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			shiftPending <= 1'b0;
		end else if (detect.cb1) begin
			shiftPending <= 1'b1;
			shiftBit     <= lineQ.cb2;
		end else if (en) begin
			shiftPending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			sr <= '0;
		end else if (cycle.wr && (cycle.sel == REG_SR)) begin
			sr <= cycle.data;
		end else if (en && shiftPending) begin
			sr <= {sr[6:0], shiftBit};	// First bit ends up in bit 7.
		end
	end

	always_comb begin
		portRead.portA = pinMerge(ora, ddra, portAIn);
		portRead.portB = pinMerge(orb, ddrb, portBIn);
		portRead.ddrA  = ddra;
		portRead.ddrB  = ddrb;
		portRead.sr    = sr;
		portRead.acr   = acr;
		portRead.pcr   = pcr;
	end

endmodule

/* timer/viaTimer1.sv */
module viaTimer1 (
	input  logic                           clk,
	input  logic                           nRESET,
	input  viaRegPkg::viaBusCycle          cycle,
	output logic                           timeout,
	output logic [viaIrqPkg::T1_WIDTH-1:0] counter,
	output logic [viaIrqPkg::T1_WIDTH-1:0] latch
);
	import viaRegPkg::*;
	import viaIrqPkg::*;

	logic en;
	logic loadHigh;
	logic running;	// Set by the first T1H write.
	logic fired;	// Zero seen, counter holds one cycle.

	assign en       = cycle.wr | cycle.rd | cycle.idle;
	assign loadHigh = cycle.wr & (cycle.sel == REG_T1H);

	// Latch writes. T1H also updates the high latch so free run reloads it.
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			latch <= '0;
		end else if (cycle.wr) begin
			case (cycle.sel)
				REG_T1L, REG_T1LL: latch[7:0]          <= cycle.data;
				REG_T1H, REG_T1LH: latch[T1_WIDTH-1:8] <= cycle.data;
				default: ;
			endcase
		end
	end

	// ##########################################################################
	// Free-run counter
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			counter <= '0;
			running <= 1'b0;
			fired   <= 1'b0;
		end else if (loadHigh) begin
			counter <= {cycle.data, latch[7:0]};	// Start.
			running <= 1'b1;
			fired   <= 1'b0;
		end else if (en) begin
			fired <= running & (counter == '0);
			if (counter == '0) begin
				counter <= latch;	// Reload.
			end else if (!fired) begin
				counter <= counter - T1_WIDTH'(1);
			end
		end
	end

	// One clk wide, in the enabled cycle after the reload.
	assign timeout = fired & en;

endmodule

/* verif/viaIrq_props.sv */
module viaIrq_props (
	input logic                                 clk,
	input logic                                 nRESET,
	input logic                                 en,
	input logic [viaIrqPkg::VIA_IRQ_BITS-1:0]   ifr,
	input logic [viaIrqPkg::VIA_IRQ_BITS-1:0]   ier,
	input logic [viaIrqPkg::VIA_IRQ_BITS-1:0]   clrVec,
	input logic                                 nIrq
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;	// Read by the testbench summary.

	// No interrupt request out of reset.
	resetHigh: assert property (@(posedge clk) !nRESET |=> nIrq)
		else begin
			failCount++;
			$error("nIrq not high after a reset cycle");
		end

	// A flag cleared in an enabled cycle stays clear, even with a set pending.
	clearWins: assert property (@(posedge clk) disable iff (!nRESET)
		en |=> ((ifr & $past(clrVec)) == '0))
		else begin
			failCount++;
			$error("IFR bit set while its clear was active");
		end

	// nIrq is registered, so it follows the active flags of the clk before.
	irqHasSource: assert property (@(posedge clk) disable iff (!nRESET)
		!nIrq |-> $past(|(ifr & ier)))
		else begin
			failCount++;
			$error("nIrq low without an enabled IFR flag");
		end

endmodule

/* verif/viaTb.sv */
module viaTb;
	timeunit 1ns;
	timeprecision 100ps;

	import viaRegPkg::*;
	import viaIrqPkg::*;

	localparam int T1_N = 20;
	localparam int WATCHDOG_NS = 40_000;	// Roughly three times the six tests end to end.
	localparam logic [7:0] PCR_EDGES = 8'h11;	// CA1/CB1 rising, CA2/CB2 falling.

	logic clk, clkEn, nRESET;
	logic cs1, nCs2, phi2, rnW;
	viaRegSel rs;
	logic [7:0] dataIn, dataOut;
	logic dataOe;
	logic [7:0] portAIn, portBIn, portAOut, portAOe, portBOut, portBOe;
	logic ca1, ca2, cb1, cb2;
	logic nIrq;

	int errorCount = 0;
	int assertFails = 0;
	logic [31:0] rngState = 32'h82e0;
	logic [VIA_IRQ_BITS-1:0] ierModel = '0;	// Expected IER contents.

	viaTbClock uClock (.clk, .clkEn, .nRESET);

	via6522 DUT (.*);

	bind viaIrqCtrl viaIrq_props irqProps (
		.clk(clk), .nRESET(nRESET), .en(en), .ifr(ifr), .ier(ier),
		.clrVec(clrVec), .nIrq(nIrq)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Per bit, the output register where the DDR bit is 1, otherwise the pin.
	function automatic logic [7:0] expectedPortRead(input logic [7:0] outReg,
			input logic [7:0] ddr, input logic [7:0] pins);
		logic [7:0] r;
		for (int b = 0; b < 8; b++) begin
			r[b] = ddr[b] ? outReg[b] : pins[b];
		end
		return r;
	endfunction

	task automatic randomByte(output logic [7:0] b);
		rngState = xorshift32(rngState);
		b = rngState[7:0];
	endtask

	task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got == exp) else begin
			errorCount++;
			$display("[FAIL] %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic expectEvent(input logic ok, input string what);
		assert (ok) else begin
			errorCount++;
			$display("Error at %0t ns: %s.", $time, what);
		end
	endtask

	// ##########################################################################
	// Bus and pin helpers
	// ##########################################################################

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// Returns 2 ns into the next cycle that has clkEn high.
	task automatic waitEnabled();
		do begin
			@(posedge clk);
			#2;
		end while (!clkEn);
	endtask

	task automatic busWrite(input viaRegSel sel, input logic [7:0] data);
		waitEnabled();
		cs1 = 1'b1;
		rnW = 1'b0;
		rs = sel;
		dataIn = data;
		@(posedge clk);
		#2;
		cs1 = 1'b0;
		rnW = 1'b1;
	endtask

	task automatic busRead(input viaRegSel sel, output logic [7:0] data);
		waitEnabled();
		cs1 = 1'b1;
		phi2 = 1'b1;
		rs = sel;
		@(negedge clk);	// Readback is combinational.
		data = dataOut;
		expectEvent(dataOe, "dataOe stayed low during a register read");
		@(posedge clk);
		#2;
		cs1 = 1'b0;
		phi2 = 1'b0;
	endtask

	task automatic writeIer(input logic [7:0] value);
		busWrite(REG_IER, value);
		if (value[7]) begin
			ierModel = ierModel | value[6:0];
		end else begin
			ierModel = ierModel & ~value[6:0];
		end
	endtask

	// Line order follows the PCR polarity bits 0, 2, 4 and 6.
	task automatic setLine(input int idx, input logic level);
		case (idx)
			0: ca1 = level;
			1: ca2 = level;
			2: cb1 = level;
			default: cb2 = level;
		endcase
	endtask

	task automatic waitIrq(input logic level, input int maxCycles, output logic seen);
		int n = 0;
		seen = (nIrq == level);
		while (!seen && n < maxCycles) begin
			waitCycles(1);
			seen = (nIrq == level);
			n++;
		end
	endtask

	// ##########################################################################
	// Directed tests
	// ##########################################################################

	task automatic testReset();
		logic [7:0] data;
		checkByte("portAOe after reset", portAOe, 8'h00);
		checkByte("portBOe after reset", portBOe, 8'h00);
		expectEvent(nIrq, "nIrq is low after reset");
		expectEvent(!dataOe, "dataOe is high outside a read");
		busRead(REG_DDRA, data);
		checkByte("DDRA after reset", data, 8'h00);
		busRead(REG_DDRB, data);
		checkByte("DDRB after reset", data, 8'h00);
		busRead(REG_IFR, data);
		checkByte("IFR after reset", data, 8'h00);
		busRead(REG_IER, data);
		checkByte("IER after reset", data, 8'h80);	// Bit 7 always reads 1.
	endtask

	task automatic testPorts();
		logic [7:0] ddrA, ddrB, outA, outB, pinA, pinB, data;
		randomByte(ddrA);
		randomByte(outA);
		randomByte(ddrB);
		randomByte(outB);
		busWrite(REG_DDRA, ddrA);
		busWrite(REG_ORA, outA);
		busWrite(REG_DDRB, ddrB);
		busWrite(REG_ORB, outB);
		checkByte("portAOe", portAOe, ddrA);
		checkByte("portAOut", portAOut, outA);
		checkByte("portBOe", portBOe, ddrB);
		checkByte("portBOut", portBOut, outB);
		randomByte(pinA);
		randomByte(pinB);
		portAIn = pinA;
		portBIn = pinB;
		busRead(REG_ORA, data);
		checkByte("port A read", data, expectedPortRead(outA, ddrA, pinA));
		busRead(REG_ORB, data);
		checkByte("port B read", data, expectedPortRead(outB, ddrB, pinB));
	endtask

	task automatic testControlLines();
		int flagPos [4] = '{IFR_CA1, IFR_CA2, IFR_CB1, IFR_CB2};
		logic [7:0] data, expIfr;
		logic rising, seen;
		busWrite(REG_PCR, PCR_EDGES);
		writeIer(8'h9B);	// All four line flags.
		for (int i = 0; i < 4; i++) begin
			rising = PCR_EDGES[2 * i];
			expIfr = 8'h80;
			expIfr[flagPos[i]] = 1'b1;
			setLine(i, rising);	// Lines rest at the opposite level.
			waitIrq(1'b0, 10, seen);
			expectEvent(seen, $sformatf("no interrupt within 10 cycles of the edge on line %0d", i));
			busRead(REG_IFR, data);
			checkByte("IFR after chosen edge", data, expIfr);
			busRead((i < 2) ? REG_ORA : REG_ORB, data);	// Clears the pair.
			busRead(REG_IFR, data);
			checkByte("IFR after port access", data, 8'h00);
			expectEvent(nIrq, $sformatf("nIrq still low after clearing line %0d", i));
			setLine(i, ~rising);
			waitCycles(10);
			busRead(REG_IFR, data);
			checkByte("IFR after opposite edge", data, 8'h00);
		end
		writeIer(8'h1B);
	endtask

	task automatic testIerAndIrq();
		logic [7:0] data;
		logic seen;
		writeIer(8'h92);
		busRead(REG_IER, data);
		checkByte("IER after set write", data, {1'b1, ierModel});
		writeIer(8'h02);
		busRead(REG_IER, data);
		checkByte("IER after clear write", data, {1'b1, ierModel});
		setLine(0, 1'b1);	// CA1 rising while not enabled.
		waitIrq(1'b0, 10, seen);
		expectEvent(!seen, "nIrq fell for a CA1 flag that is not enabled");
		busRead(REG_IFR, data);
		checkByte("IFR with CA1 disabled", data, 8'h02);
		writeIer(8'h82);
		waitIrq(1'b0, 10, seen);
		expectEvent(seen, "nIrq did not fall after CA1 was enabled");
		busWrite(REG_IFR, 8'h02);
		waitIrq(1'b1, 10, seen);
		expectEvent(seen, "nIrq did not rise after the IFR mask write");
		busRead(REG_IFR, data);
		checkByte("IFR after mask write", data, 8'h00);
		setLine(0, 1'b0);
		writeIer(8'h7F);
	endtask

	task automatic testTimer1();
		logic [7:0] data;
		logic seen;
		int k;
		busWrite(REG_T1L, 8'(T1_N));
		busWrite(REG_T1H, 8'h00);
		seen = 1'b0;
		k = 0;
		while (!seen && k < T1_N + 4) begin	// Read k sees k-1 counted cycles.
			k++;
			busRead(REG_IFR, data);
			seen = data[IFR_T1];
		end
		expectEvent(seen, "Timer 1 flag not set by enabled cycle N+3");
		expectEvent(k > T1_N + 1, "Timer 1 flag set within the first N enabled cycles");
		busRead(REG_T1L, data);
		busRead(REG_IFR, data);
		checkByte("IFR timer bit after T1L read", data & 8'h40, 8'h00);
		seen = 1'b0;
		k = 0;
		while (!seen && k < T1_N + 2) begin
			k++;
			busRead(REG_IFR, data);
			seen = data[IFR_T1];
		end
		expectEvent(seen && k >= T1_N - 2, "Timer 1 flag did not set again one period later");
	endtask

	task automatic testShiftIn();
		logic [7:0] data, expected, rnd;
		expected = '0;
		busWrite(REG_PCR, 8'h10);	// CB1 on the rising edge.
		for (int i = 0; i < 8; i++) begin
			randomByte(rnd);
			cb2 = rnd[0];
			waitCycles(1);
			cb1 = 1'b1;
			waitCycles(4);
			cb1 = 1'b0;
			waitCycles(4);
			expected = {expected[6:0], rnd[0]};	// First bit ends at the top.
		end
		busRead(REG_SR, data);
		checkByte("SR after eight CB1 edges", data, expected);
	endtask

	// ##########################################################################
	// Main sequence and watchdog
	// ##########################################################################

	initial begin
		cs1 = 1'b0;
		nCs2 = 1'b0;
		phi2 = 1'b0;
		rnW = 1'b1;
		rs = REG_ORB;
		dataIn = 8'h00;
		portAIn = 8'h00;
		portBIn = 8'h00;
		ca1 = 1'b0;
		ca2 = 1'b1;
		cb1 = 1'b0;
		cb2 = 1'b1;
		wait (nRESET === 1'b1);
		testReset();
		testPorts();
		testControlLines();
		testIerAndIrq();
		testTimer1();
		testShiftIn();
		assertFails = DUT.uIrqCtrl.irqProps.failCount;
		$display("Checks complete with %0d error(s) and %0d assertion failure(s)",
			errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish.", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verif/viaTbClock.sv */
module viaTbClock (
	output logic clk,
	output logic clkEn,
	output logic nRESET
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 20;	// 40 ns clock.
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Enable on every second clk, moved 1 ns after the edge, ahead of the bus stimulus.
	initial begin
		clkEn = 1'b0;
		forever begin
			@(posedge clk);
			#1 clkEn = ~clkEn;
		end
	end

	initial begin
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 nRESET = 1'b1;
	end

endmodule

/* via6522.f */
common/viaRegPkg.sv
common/viaIrqPkg.sv
design/viaBusDecode.sv
ports/viaPortCtrl.sv
timer/viaTimer1.sv
design/viaIrqCtrl.sv
design/via6522.sv
verif/viaTbClock.sv
verif/viaIrq_props.sv
verif/viaTb.sv
